//--- common/frame_consts.svh
// frame geometry, memory depth and credit limit, included by design and testbench files
`ifndef FRAME_CONSTS_SVH
`define FRAME_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// frame geometry
////////////////////////////////////////////////////////////////////////////
`define FRAME_ROWS   24    // rows per camera frame
`define FRAME_COLS   32    // columns per camera frame
`define FRAME_PIXELS 768   // rows x cols
`define OUT_COLS     34    // image columns plus left and right pad column

////////////////////////////////////////////////////////////////////////////
// storage and flow control
////////////////////////////////////////////////////////////////////////////
`define MEM_DEPTH    1536  // two banks of one frame each
`define CREDIT_MAX   4     // buffer slots on the PE array side

`endif

//--- common/frame_pkg.sv
// shared types for the input stage, imported by design modules and the testbench
package frame_pkg;

  typedef logic [7:0]   pixel_t;     // pixel or pad byte
  typedef logic [10:0]  mem_addr_t;  // {bank, row, col}
  typedef logic [207:0] col_word_t;  // 26 bytes, pad on top and bottom
  typedef logic [4:0]   row_idx_t;
  typedef logic [5:0]   col_idx_t;   // wide enough for 34 output columns
  typedef logic [2:0]   credit_t;    // 0 .. CREDIT_MAX

  // column assembler states
  typedef enum logic [1:0] {
    ASM_IDLE,         // no frame handed over
    ASM_WAIT_CREDIT,  // next column ready to start, waiting on the consumer
    ASM_FETCH,        // reading 24 pixels of one column
    ASM_SEND          // column word on the output for one cycle
  } asm_state_t;

endpackage

//--- design/frame_mem.sv
// single-port two-bank frame memory with one cycle read latency, used behind the arbiter
`timescale 1ns/1ps
`include "frame_consts.svh"

module frame_mem import frame_pkg::*; (
  input  logic      dout_clk,
  input  logic      i_we,
  input  mem_addr_t i_addr,
  input  pixel_t    i_wdata,
  output pixel_t    o_rdata
);

  ////////////////////////////////////////////////////////////////////////////
  // storage array, bank 0 in the lower half and bank 1 in the upper half
  ////////////////////////////////////////////////////////////////////////////
  pixel_t      mem_q [`MEM_DEPTH];
  logic [10:0] mem_idx;  // bank 1 starts right after the last pixel of bank 0

  assign mem_idx = i_addr[10] ? 11'(`FRAME_PIXELS) + 11'(i_addr[9:0]) : 11'(i_addr[9:0]);

  always_ff @(posedge dout_clk) begin
    if (i_we) begin
      mem_q[mem_idx] <= i_wdata;  // write at the edge
    end else begin
      o_rdata <= mem_q[mem_idx];  // data valid one cycle later
    end
  end

endmodule

//--- design/frame_mem_arbiter.sv
// shares the frame memory port between pixel writer and column assembler, writer first
`timescale 1ns/1ps

module frame_mem_arbiter import frame_pkg::*; (
  input  logic      dout_clk,
  input  logic      rst_n,
  // writer side, always served
  input  logic      i_wr_req,
  input  mem_addr_t i_wr_addr,
  input  pixel_t    i_wr_data,
  // assembler side
  input  logic      i_rd_req,
  input  mem_addr_t i_rd_addr,
  output logic      o_rd_gnt,
  output pixel_t    o_rd_data,
  output logic      o_rd_data_vld
);

  mem_addr_t mem_addr;

  // a camera pixel cannot wait, so reads only get the idle cycles
  assign o_rd_gnt = i_rd_req && !i_wr_req;
  assign mem_addr = i_wr_req ? i_wr_addr : i_rd_addr;  // winner drives the address

  // read data shows up one cycle after the grant
  always_ff @(posedge dout_clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rd_data_vld <= 1'b0;
    end else begin
      o_rd_data_vld <= o_rd_gnt;
    end
  end

  frame_mem frame_mem_inst (
    .dout_clk (dout_clk),
    .i_we     (i_wr_req),
    .i_addr   (mem_addr),
    .i_wdata  (i_wr_data),
    .o_rdata  (o_rd_data)
  );

endmodule

//--- design/pixel_writer.sv
// writes the camera stream into the write bank and hands full frames to the assembler
`timescale 1ns/1ps
`include "frame_consts.svh"

module pixel_writer import frame_pkg::*; (
  input  logic      dout_clk,
  input  logic      rst_n,
  input  pixel_t    i_pix,
  input  logic      i_pix_vld,
  input  pixel_t    i_pad_value,
  input  logic      i_rd_done,
  output logic      o_wr_req,
  output mem_addr_t o_wr_addr,
  output pixel_t    o_wr_data,
  output logic      o_frame_avail,
  output logic      o_rd_bank,
  output pixel_t    o_frame_pad,
  output logic      o_frame_drop
);

  row_idx_t row_cnt;
  col_idx_t col_cnt;
  logic     wr_bank;      // bank being filled
  logic     reader_busy;  // assembler still owns the other bank
  logic     last_pix;
  logic     reader_free;

  assign last_pix    = i_pix_vld && (row_cnt == row_idx_t'(`FRAME_ROWS - 1)) &&
                       (col_cnt == col_idx_t'(`FRAME_COLS - 1));
  assign reader_free = !reader_busy || i_rd_done;  // done in the same cycle counts

  // every valid pixel goes straight to memory
  assign o_wr_req  = i_pix_vld;
  assign o_wr_addr = {wr_bank, row_cnt, col_cnt[4:0]};  // row * 32 + col
  assign o_wr_data = i_pix;

  ////////////////////////////////////////////////////////////////////////////
  // raster counters, bank swap and handoff
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge dout_clk or negedge rst_n) begin
    if (!rst_n) begin
      row_cnt       <= '0;
      col_cnt       <= '0;
      wr_bank       <= 1'b0;
      reader_busy   <= 1'b0;
      o_frame_avail <= 1'b0;
      o_frame_drop  <= 1'b0;
    end else begin
      o_frame_avail <= last_pix && reader_free;
      o_frame_drop  <= last_pix && !reader_free;  // same bank is overwritten next frame
      if (i_pix_vld) begin
        if (col_cnt == col_idx_t'(`FRAME_COLS - 1)) begin
          col_cnt <= '0;
          row_cnt <= last_pix ? '0 : row_cnt + 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
      if (last_pix && reader_free) begin
        wr_bank     <= ~wr_bank;
        reader_busy <= 1'b1;
      end else if (i_rd_done) begin
        reader_busy <= 1'b0;
      end
    end
  end

  // frame descriptor, meaningful only with o_frame_avail
  always_ff @(posedge dout_clk) begin
    if (last_pix) begin
      o_rd_bank   <= wr_bank;
      o_frame_pad <= i_pad_value;  // pad byte sampled at the last pixel
    end
  end

endmodule

//--- column_assembler/column_assembler.sv
// reads a finished bank column by column and sends padded column words under credit control
`timescale 1ns/1ps
`include "frame_consts.svh"

module column_assembler import frame_pkg::*; (
  input  logic      dout_clk,
  input  logic      rst_n,
  // frame handoff from the writer
  input  logic      i_frame_avail,
  input  logic      i_rd_bank,
  input  pixel_t    i_frame_pad,
  // memory read through the arbiter
  input  logic      i_rd_gnt,
  input  pixel_t    i_rd_data,
  input  logic      i_rd_data_vld,
  // consumer side
  input  logic      i_credit,
  output logic      o_rd_req,
  output mem_addr_t o_rd_addr,
  output logic      o_rd_done,
  output logic      o_col_vld,
  output col_word_t o_col_data,
  output logic      o_col_last
);

  asm_state_t               state;
  col_idx_t                 col_cnt;   // output column 0 .. 33
  col_idx_t                 img_col;   // image column behind it
  row_idx_t                 req_row;   // next row to request
  row_idx_t                 rcv_cnt;   // rows returned so far
  credit_t                  credits;
  logic                     bank_q;
  pixel_t                   pad_q;
  logic [`FRAME_ROWS*8-1:0] pix_sr;    // row 0 ends up on top
  logic                     pad_col;
  logic                     last_col;
  logic                     send;

  assign img_col  = col_cnt - 1'b1;
  assign pad_col  = (col_cnt == '0) || (col_cnt == col_idx_t'(`OUT_COLS - 1));
  assign last_col = (col_cnt == col_idx_t'(`OUT_COLS - 1));
  assign send     = (state == ASM_SEND);

  assign o_rd_addr = {bank_q, req_row, img_col[4:0]};

  // column word is valid for the single cycle spent in the send state
  assign o_col_vld  = send;
  assign o_col_last = send && last_col;
  assign o_col_data = pad_col ? {(`FRAME_ROWS + 2){pad_q}} : {pad_q, pix_sr, pad_q};

  ////////////////////////////////////////////////////////////////////////////
  // column sequencing
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge dout_clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ASM_IDLE;
      col_cnt   <= '0;
      req_row   <= '0;
      rcv_cnt   <= '0;
      o_rd_req  <= 1'b0;
      o_rd_done <= 1'b0;
    end else begin
      o_rd_done <= 1'b0;
      case (state)
        ASM_IDLE: begin
          if (i_frame_avail) begin
            col_cnt <= '0;
            state   <= ASM_WAIT_CREDIT;
          end
        end
        ASM_WAIT_CREDIT: begin
          if (credits != '0) begin  // no memory traffic while starved
            if (pad_col) begin
              state <= ASM_SEND;
            end else begin
              req_row  <= '0;
              rcv_cnt  <= '0;
              o_rd_req <= 1'b1;
              state    <= ASM_FETCH;
            end
          end
        end
        ASM_FETCH: begin
          // requests and returns overlap, one read can be in flight per cycle
          if (i_rd_gnt) begin
            req_row <= req_row + 1'b1;
            if (req_row == row_idx_t'(`FRAME_ROWS - 1)) begin
              o_rd_req <= 1'b0;
            end
          end
          if (i_rd_data_vld) begin
            rcv_cnt <= rcv_cnt + 1'b1;
            if (rcv_cnt == row_idx_t'(`FRAME_ROWS - 1)) begin
              state <= ASM_SEND;
            end
          end
        end
        ASM_SEND: begin
          col_cnt <= col_cnt + 1'b1;
          if (last_col) begin
            o_rd_done <= 1'b1;  // bank goes back to the writer
            state     <= ASM_IDLE;
          end else begin
            state <= ASM_WAIT_CREDIT;
          end
        end
        default: state <= ASM_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // credits, one spent per column word and one back per pulse
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge dout_clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= credit_t'(`CREDIT_MAX);
    end else begin
      case ({send, i_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // both or neither cancel out
      endcase
    end
  end

  // frame descriptor and pixel column
  always_ff @(posedge dout_clk) begin
    if ((state == ASM_IDLE) && i_frame_avail) begin
      bank_q <= i_rd_bank;
      pad_q  <= i_frame_pad;
    end
    if (i_rd_data_vld) begin
      pix_sr <= {pix_sr[`FRAME_ROWS*8-9:0], i_rd_data};  // shift up, newest row at bottom
    end
  end

endmodule

//--- design/input_pre_top.sv
// top of the camera input stage, wires writer, arbiter with frame memory and assembler
`timescale 1ns/1ps

module input_pre_top import frame_pkg::*; (
  input  logic      dout_clk,
  input  logic      rst_n,
  // camera side
  input  pixel_t    i_pix,
  input  logic      i_pix_vld,
  input  pixel_t    i_pad_value,
  // PE array side
  input  logic      i_credit,
  output logic      o_col_vld,
  output col_word_t o_col_data,
  output logic      o_col_last,
  output logic      o_frame_drop
);

  ////////////////////////////////////////////////////////////////////////////
  // internal connections
  ////////////////////////////////////////////////////////////////////////////
  logic      wr_req;
  mem_addr_t wr_addr;
  pixel_t    wr_data;
  logic      rd_req;
  mem_addr_t rd_addr;
  logic      rd_gnt;
  pixel_t    rd_data;
  logic      rd_data_vld;
  logic      frame_avail;
  logic      rd_bank;
  pixel_t    frame_pad;
  logic      rd_done;

  pixel_writer pixel_writer_inst (
    .dout_clk      (dout_clk),
    .rst_n         (rst_n),
    .i_pix         (i_pix),
    .i_pix_vld     (i_pix_vld),
    .i_pad_value   (i_pad_value),
    .i_rd_done     (rd_done),
    .o_wr_req      (wr_req),
    .o_wr_addr     (wr_addr),
    .o_wr_data     (wr_data),
    .o_frame_avail (frame_avail),
    .o_rd_bank     (rd_bank),
    .o_frame_pad   (frame_pad),
    .o_frame_drop  (o_frame_drop)
  );

  frame_mem_arbiter frame_mem_arbiter_inst (
    .dout_clk      (dout_clk),
    .rst_n         (rst_n),
    .i_wr_req      (wr_req),
    .i_wr_addr     (wr_addr),
    .i_wr_data     (wr_data),
    .i_rd_req      (rd_req),
    .i_rd_addr     (rd_addr),
    .o_rd_gnt      (rd_gnt),
    .o_rd_data     (rd_data),
    .o_rd_data_vld (rd_data_vld)
  );

  column_assembler column_assembler_inst (
    .dout_clk      (dout_clk),
    .rst_n         (rst_n),
    .i_frame_avail (frame_avail),
    .i_rd_bank     (rd_bank),
    .i_frame_pad   (frame_pad),
    .i_rd_gnt      (rd_gnt),
    .i_rd_data     (rd_data),
    .i_rd_data_vld (rd_data_vld),
    .i_credit      (i_credit),
    .o_rd_req      (rd_req),
    .o_rd_addr     (rd_addr),
    .o_rd_done     (rd_done),
    .o_col_vld     (o_col_vld),
    .o_col_data    (o_col_data),
    .o_col_last    (o_col_last)
  );

endmodule

//--- verification/input_pre_props.sv
// assertions bound into the frame memory arbiter and the column assembler by the testbench
`timescale 1ns/1ps
`include "frame_consts.svh"

module input_pre_props import frame_pkg::*; (
  input  logic    dout_clk,
  input  logic    rst_n,
  input  logic    i_wr_req,
  input  logic    i_rd_req,
  input  logic    i_rd_gnt,
  input  logic    i_rd_data_vld,
  input  logic    i_col_vld,
  input  credit_t i_credits
);

  ////////////////////////////////////////////////////////////////////////////
  // shared memory port
  ////////////////////////////////////////////////////////////////////////////
  ap_no_gnt_on_write: assert property (@(posedge dout_clk) disable iff (!rst_n)
    i_rd_gnt |-> !i_wr_req)
    else $error("read grant in a cycle with a write request");

  ap_gnt_needs_req: assert property (@(posedge dout_clk) disable iff (!rst_n)
    i_rd_gnt |-> i_rd_req)
    else $error("read grant without a read request");

  ap_vld_after_gnt: assert property (@(posedge dout_clk) disable iff (!rst_n)
    i_rd_gnt |=> i_rd_data_vld)
    else $error("read data valid missing one cycle after a grant");

  ap_vld_from_gnt: assert property (@(posedge dout_clk) disable iff (!rst_n)
    i_rd_data_vld |-> $past(i_rd_gnt))
    else $error("read data valid without a grant one cycle before");

  ////////////////////////////////////////////////////////////////////////////
  // credit flow
  ////////////////////////////////////////////////////////////////////////////
  ap_col_with_credit: assert property (@(posedge dout_clk) disable iff (!rst_n)
    i_col_vld |-> (i_credits != '0))
    else $error("column word sent with no credit in hand");

  ap_credit_bound: assert property (@(posedge dout_clk) disable iff (!rst_n)
    i_credits <= credit_t'(`CREDIT_MAX))
    else $error("credit counter above the consumer buffer size");

endmodule

//--- verification/input_pre_checker.sv
// watches the DUT ports, models the expected column words of each accepted frame and compares
`timescale 1ns/1ps
`include "frame_consts.svh"

module input_pre_checker import frame_pkg::*; (
  input  logic      dout_clk,
  input  logic      rst_n,
  input  pixel_t    i_pix,
  input  logic      i_pix_vld,
  input  pixel_t    i_pad_value,
  input  logic      i_credit,
  input  logic      i_col_vld,
  input  col_word_t i_col_data,
  input  logic      i_col_last,
  input  logic      i_frame_drop,
  output int        o_err_cnt,
  output int        o_frames_rx,
  output int        o_frames_dropped
);

  pixel_t    cur_frame [`FRAME_PIXELS];  // frame coming in from the camera
  pixel_t    exp_pix [$];                // accepted frames, one after the other
  pixel_t    exp_pad [$];
  pixel_t    pend_pad;
  logic      pend;                       // drop decision due this cycle
  col_word_t exp_word;
  int        pix_idx;
  int        out_col;
  int        in_flight;                  // words sent but not credited
  int        i;

  // column col of the oldest accepted frame, pad byte on top and at the bottom
  function automatic col_word_t expected_column(input int col);
    col_word_t word;
    pixel_t    pad;
    int        r;
    pad = exp_pad[0];
    for (r = 0; r < `FRAME_ROWS + 2; r++) begin
      word[8*r +: 8] = pad;
    end
    if (col > 0 && col < `OUT_COLS - 1) begin
      for (r = 0; r < `FRAME_ROWS; r++) begin
        word[(`FRAME_ROWS + 1) * 8 - 1 - 8*r -: 8] = exp_pix[r * `FRAME_COLS + col - 1];
      end
    end
    return word;
  endfunction

  always @(negedge dout_clk) begin
    if (!rst_n) begin
      o_err_cnt        = 0;
      o_frames_rx      = 0;
      o_frames_dropped = 0;
      pend             = 1'b0;
      pix_idx          = 0;
      out_col          = 0;
      in_flight        = 0;
    end else begin
      if (pend) begin  // one cycle after the last pixel
        pend = 1'b0;
        if (i_frame_drop) begin
          o_frames_dropped++;
        end else begin
          for (i = 0; i < `FRAME_PIXELS; i++) begin
            exp_pix.push_back(cur_frame[i]);
          end
          exp_pad.push_back(pend_pad);
        end
      end else if (i_frame_drop) begin
        o_err_cnt++;
        $display("CHECK FAILED t=%0t o_frame_drop: got 1 expected 0", $time);
      end
      if (i_pix_vld) begin
        cur_frame[pix_idx] = i_pix;
        if (pix_idx == `FRAME_PIXELS - 1) begin
          pend     = 1'b1;
          pend_pad = i_pad_value;  // pad byte taken at the last pixel
          pix_idx  = 0;
        end else begin
          pix_idx++;
        end
      end
      if (i_col_last && !i_col_vld) begin
        o_err_cnt++;
        $display("CHECK FAILED t=%0t o_col_last: got 1 expected 0", $time);
      end
      if (i_col_vld) begin
        if (in_flight >= `CREDIT_MAX) begin
          o_err_cnt++;
          $display("CHECK FAILED t=%0t words in flight: got %0d expected at most %0d",
                   $time, in_flight + 1, `CREDIT_MAX);
        end
        if (exp_pad.size() == 0) begin
          o_err_cnt++;
          $display("column word at %0t arrived while no frame was expected", $time);
        end else begin
          exp_word = expected_column(out_col);
          if (i_col_data !== exp_word) begin
            o_err_cnt++;
            $display("CHECK FAILED t=%0t o_col_data col %0d: got %h expected %h",
                     $time, out_col, i_col_data, exp_word);
          end
          if (i_col_last !== (out_col == `OUT_COLS - 1)) begin
            o_err_cnt++;
            $display("CHECK FAILED t=%0t o_col_last col %0d: got %b expected %b",
                     $time, out_col, i_col_last, out_col == `OUT_COLS - 1);
          end
          if (out_col == `OUT_COLS - 1) begin
            out_col = 0;
            for (i = 0; i < `FRAME_PIXELS; i++) begin
              void'(exp_pix.pop_front());
            end
            void'(exp_pad.pop_front());
            o_frames_rx++;
          end else begin
            out_col++;
          end
        end
      end
      in_flight = in_flight + int'(i_col_vld) - int'(i_credit);
    end
  end

endmodule

//--- verification/input_pre_tb.sv
// testbench top for the camera input stage, runs the frames listed in the test data file
`timescale 1ns/1ps
`include "frame_consts.svh"

module input_pre_tb import frame_pkg::*; ();

  localparam int MAX_FRAMES = 16;     // lines the data file may hold
  localparam int WAIT_LIMIT = 20000;  // cycles for the last frames to drain

  logic        dout_clk = 1'b0;
  logic        rst_n;
  pixel_t      i_pix;
  logic        i_pix_vld;
  pixel_t      i_pad_value;
  logic        i_credit;
  logic        o_col_vld;
  col_word_t   o_col_data;
  logic        o_col_last;
  logic        o_frame_drop;

  logic [15:0] testdata [3 * MAX_FRAMES];  // pad, gap, credit delay per frame
  logic [15:0] lfsr;
  int          n_frames;
  int          exp_drops;
  int          credit_delay;
  int          cycle_cnt;
  int          last_due;
  int          due;
  int          due_q [$];                  // cycles at which credits go back
  int          err_cnt;
  int          frames_rx;
  int          frames_dropped;
  int          timeout_errs;
  int          drop_errs;
  int          f;
  int          w;

  always #50 dout_clk = ~dout_clk;

  input_pre_top input_pre_top_inst (
    .dout_clk     (dout_clk),
    .rst_n        (rst_n),
    .i_pix        (i_pix),
    .i_pix_vld    (i_pix_vld),
    .i_pad_value  (i_pad_value),
    .i_credit     (i_credit),
    .o_col_vld    (o_col_vld),
    .o_col_data   (o_col_data),
    .o_col_last   (o_col_last),
    .o_frame_drop (o_frame_drop)
  );

  input_pre_checker input_pre_checker_inst (
    .dout_clk         (dout_clk),
    .rst_n            (rst_n),
    .i_pix            (i_pix),
    .i_pix_vld        (i_pix_vld),
    .i_pad_value      (i_pad_value),
    .i_credit         (i_credit),
    .i_col_vld        (o_col_vld),
    .i_col_data       (o_col_data),
    .i_col_last       (o_col_last),
    .i_frame_drop     (o_frame_drop),
    .o_err_cnt        (err_cnt),
    .o_frames_rx      (frames_rx),
    .o_frames_dropped (frames_dropped)
  );

  // arbiter side sees no column traffic, assembler side sees no write request
  bind frame_mem_arbiter input_pre_props arbiter_props_inst (
    .dout_clk (dout_clk), .rst_n (rst_n), .i_wr_req (i_wr_req), .i_rd_req (i_rd_req),
    .i_rd_gnt (o_rd_gnt), .i_rd_data_vld (o_rd_data_vld), .i_col_vld (1'b0),
    .i_credits (3'(`CREDIT_MAX))
  );
  bind column_assembler input_pre_props assembler_props_inst (
    .dout_clk (dout_clk), .rst_n (rst_n), .i_wr_req (1'b0), .i_rd_req (o_rd_req),
    .i_rd_gnt (i_rd_gnt), .i_rd_data_vld (i_rd_data_vld), .i_col_vld (o_col_vld),
    .i_credits (credits)
  );

  ////////////////////////////////////////////////////////////////////////////
  // pixel stimulus
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  task automatic next_pixel(output pixel_t px);
    px = '0;
    repeat (8) begin
      lfsr = lfsr_step(lfsr);
      px   = {px[6:0], lfsr[0]};
    end
  endtask

  task automatic send_frame(input pixel_t pad);
    pixel_t px;
    int     i;
    for (i = 0; i < `FRAME_PIXELS; i++) begin
      @(posedge dout_clk);
      #1;
      next_pixel(px);
      i_pix       = px;
      i_pix_vld   = 1'b1;
      i_pad_value = (i == `FRAME_PIXELS - 1) ? pad : ~pad;  // only the last one counts
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge dout_clk);
      #1;
      i_pix_vld = 1'b0;
    end
  endtask

  task automatic wait_for_frames(input int total);
    int waited;
    waited = 0;
    while (frames_rx + frames_dropped < total && waited < WAIT_LIMIT) begin
      @(posedge dout_clk);
      waited++;
    end
    if (frames_rx + frames_dropped < total) begin
      timeout_errs++;
      $display("timeout: only %0d of %0d frames were sent out or dropped",
               frames_rx + frames_dropped, total);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d checker, %0d drop count, %0d timeout (frames out %0d, dropped %0d)",
             err_cnt, drop_errs, timeout_errs, frames_rx, frames_dropped);
    if (err_cnt + drop_errs + timeout_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // credit return, one pulse per column word after the current delay
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    i_credit  = 1'b0;
    cycle_cnt = 0;
    last_due  = 0;
    forever begin
      @(posedge dout_clk);
      #1;
      cycle_cnt++;
      i_credit = 1'b0;
      if (!rst_n) begin
        due_q.delete();
      end else begin
        if (due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
          i_credit = 1'b1;
          void'(due_q.pop_front());
        end
        if (o_col_vld) begin  // word taken at the next edge
          due = cycle_cnt + credit_delay;
          if (due < last_due + 2) begin
            due = last_due + 2;  // pulses stay apart and in order
          end
          due_q.push_back(due);
          last_due = due;
        end
      end
    end
  end

  initial begin
    rst_n        = 1'b0;
    i_pix        = '0;
    i_pix_vld    = 1'b0;
    i_pad_value  = '0;
    lfsr         = 16'd73;
    credit_delay = 2;
    n_frames     = 0;
    exp_drops    = 0;
    timeout_errs = 0;
    drop_errs    = 0;
    for (w = 0; w < 3 * MAX_FRAMES; w++) begin
      testdata[w] = 16'hffff;  // marks unused lines
    end
    $readmemh("verification/input_pre_testdata.txt", testdata);
    while (n_frames < MAX_FRAMES && testdata[3 * n_frames] != 16'hffff) begin
      n_frames++;
    end
    repeat (4) @(posedge dout_clk);
    #1 rst_n = 1'b1;
    for (f = 0; f < n_frames; f++) begin
      credit_delay = int'(testdata[3*f + 2]);
      // the writer owns every memory cycle of a back-to-back frame, the reader keeps its bank
      if (f > 0 && testdata[3*f + 1] == 16'h0000) begin
        exp_drops++;
      end
      idle_cycles(int'(testdata[3*f + 1]));
      send_frame(testdata[3*f][7:0]);
    end
    idle_cycles(1);
    wait_for_frames(n_frames);
    if (frames_dropped != exp_drops) begin
      drop_errs++;
      $display("CHECK FAILED t=%0t o_frame_drop pulses: got %0d expected %0d",
               $time, frames_dropped, exp_drops);
    end
    finish_run();
  end

endmodule

//--- verification/input_pre_testdata.txt
// pad byte, idle cycles before the frame, cycles from a column word to its credit (all hex)
// gap 0000 sends the frame right behind the previous one
A5 0010 0002
3C 0C00 0003
E1 0C00 0040
5A 0C00 0100
96 0000 0100
0F 0000 0100
C3 1000 0008
7E 0C00 0001

//--- project.f
+incdir+common
common/frame_pkg.sv
design/frame_mem.sv
design/frame_mem_arbiter.sv
design/pixel_writer.sv
column_assembler/column_assembler.sv
design/input_pre_top.sv
verification/input_pre_props.sv
verification/input_pre_checker.sv
verification/input_pre_tb.sv

//--- Makefile
# Verilator build and run of the camera input stage testbench

all: run

obj_dir/Vinput_pre_tb: project.f $(shell grep -v '^+' project.f) $(wildcard common/*.svh)
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f --top-module input_pre_tb

run: obj_dir/Vinput_pre_tb
	./obj_dir/Vinput_pre_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Something failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Everything OK" sim.log; then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
